// File: design/uart_str_pkg.sv
//////////////////////////////
// shared definitions of the string link
// character type and frame delimiter
// framer and deframer state encodings
//////////////////////////////
`default_nettype none

package uart_str_pkg;

	// one character on the line
	typedef logic [7:0] byte_t;

	// frames look like &&payload&&
	localparam byte_t DELIM = 8'h26;

	// transmit framer
	typedef enum logic [2:0] {
		FTX_IDLE    = 3'd0,
		FTX_LEAD0   = 3'd1,
		FTX_LEAD1   = 3'd2,
		FTX_PAYLOAD = 3'd3,
		FTX_TAIL0   = 3'd4,
		FTX_TAIL1   = 3'd5
	} ftx_state_t;

	// receive deframer
	typedef enum logic [1:0] {
		FRX_HUNT    = 2'd0,
		FRX_LEAD1   = 2'd1,
		FRX_PAYLOAD = 2'd2,
		FRX_TAIL1   = 2'd3
	} frx_state_t;

endpackage

`default_nettype wire

// File: design/uart_tx.sv
//////////////////////////////
// 8N1 UART serializer
// byte valid/ready input, baud counter
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int unsigned CLK_FREQ  = 125_000_000,
	parameter int unsigned BAUD_RATE = 115_200
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,
	input  wire uart_str_pkg::byte_t data,
	input  wire                 valid,
	output logic                ready,
	output logic                txd
);

	localparam int unsigned BIT_CYC = CLK_FREQ / BAUD_RATE;
	localparam int unsigned CNT_W   = (BIT_CYC > 1) ? $clog2(BIT_CYC) : 1;

	logic             busy;
	logic [CNT_W-1:0] baud_cnt;
	// number of bit periods already completed
	logic [3:0]       bit_cnt;
	// data bits followed by the stop bit
	logic [8:0]       frame_q;

	assign ready = ~busy;

	always_ff @(posedge sys_clk) begin
		if (ready && valid) begin
			frame_q <= {1'b1, data};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= 4'd0;
			txd      <= 1'b1;
		end else if (!busy) begin
			if (valid) begin
				// start bit goes out right after acceptance
				busy     <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= 4'd0;
				txd      <= 1'b0;
			end
		end else if (baud_cnt == CNT_W'(BIT_CYC - 1)) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				// stop bit done and the line stays high
				busy <= 1'b0;
				txd  <= 1'b1;
			end else begin
				// LSB first with the stop bit at index 8
				txd     <= frame_q[bit_cnt];
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + CNT_W'(1);
		end
	end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
//////////////////////////////
// 8N1 UART deserializer
// two-stage line synchronizer
// mid-bit sampling, stop error flag
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int unsigned CLK_FREQ  = 125_000_000,
	parameter int unsigned BAUD_RATE = 115_200
) (
	input  wire                 sys_clk,
	input  wire                 sys_rst_n,
	input  wire                 rxd,
	output uart_str_pkg::byte_t data,
	output logic                valid,
	output logic                stop_err
);

	localparam int unsigned BIT_CYC = CLK_FREQ / BAUD_RATE;
	localparam int unsigned HALF    = BIT_CYC / 2;
	localparam int unsigned CNT_W   = (BIT_CYC > 1) ? $clog2(BIT_CYC) : 1;

	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_prev;
	logic             fall;
	logic             busy;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]       bit_idx;
	logic [CNT_W-1:0] baud_cnt;
	logic             sample_pt;
	logic [7:0]       shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign fall = rxd_prev & ~rxd_sync;

	// half a bit to the start bit centre and whole bits after
	assign sample_pt = (bit_idx == 4'd0) ? (baud_cnt == CNT_W'(HALF - 1))
	                                     : (baud_cnt == CNT_W'(BIT_CYC - 1));

	always_ff @(posedge sys_clk) begin
		if (busy && sample_pt && bit_idx != 4'd0 && bit_idx != 4'd9) begin
			shreg <= {rxd_sync, shreg[7:1]};
		end
	end

	// stable from the stop bit until the next data bit
	assign data = shreg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			bit_idx  <= 4'd0;
			baud_cnt <= '0;
			valid    <= 1'b0;
			stop_err <= 1'b0;
		end else begin
			valid    <= 1'b0;
			stop_err <= 1'b0;
			if (!busy) begin
				if (fall) begin
					busy     <= 1'b1;
					bit_idx  <= 4'd0;
					baud_cnt <= '0;
				end
			end else if (sample_pt) begin
				baud_cnt <= '0;
				if (bit_idx == 4'd0 && rxd_sync) begin
					// start bit gone by mid-bit so only a glitch
					busy <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					busy     <= 1'b0;
					valid    <= rxd_sync;
					stop_err <= ~rxd_sync;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: design/frame_tx.sv
//////////////////////////////
// string framer
// string request in, &&payload&& bytes out
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_tx #(
	parameter int unsigned  MAX_LEN = 16,
	localparam int unsigned LEN_W   = $clog2(MAX_LEN + 1)
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire [8*MAX_LEN-1:0]   str,
	input  wire [LEN_W-1:0]       len,
	input  wire                   valid,
	output logic                  ready,
	output uart_str_pkg::byte_t   byte_data,
	output logic                  byte_valid,
	input  wire                   byte_ready
);

	uart_str_pkg::ftx_state_t state;
	logic [8*MAX_LEN-1:0]     str_q;
	logic [LEN_W-1:0]         len_q;
	logic [LEN_W-1:0]         idx;
	// last delimiter handed over while the serializer still sends it
	logic                     tail_sent;
	logic                     handshake;

	assign ready      = (state == uart_str_pkg::FTX_IDLE);
	assign byte_valid = (state != uart_str_pkg::FTX_IDLE) && !tail_sent;
	assign handshake  = byte_valid && byte_ready;

	always_comb begin
		if (state == uart_str_pkg::FTX_PAYLOAD) begin
			byte_data = str_q[8*idx +: 8];
		end else begin
			byte_data = uart_str_pkg::DELIM;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (ready && valid) begin
			str_q <= str;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= uart_str_pkg::FTX_IDLE;
			len_q     <= '0;
			idx       <= '0;
			tail_sent <= 1'b0;
		end else begin
			case (state)
				uart_str_pkg::FTX_IDLE: begin
					if (valid) begin
						state <= uart_str_pkg::FTX_LEAD0;
						len_q <= (len > LEN_W'(MAX_LEN)) ? LEN_W'(MAX_LEN) : len;
						idx   <= '0;
					end
				end
				uart_str_pkg::FTX_LEAD0: begin
					if (handshake) state <= uart_str_pkg::FTX_LEAD1;
				end
				uart_str_pkg::FTX_LEAD1: begin
					// empty string goes straight to the tail
					if (handshake) begin
						state <= (len_q == '0) ? uart_str_pkg::FTX_TAIL0
						                       : uart_str_pkg::FTX_PAYLOAD;
					end
				end
				uart_str_pkg::FTX_PAYLOAD: begin
					if (handshake) begin
						if (idx == len_q - LEN_W'(1)) begin
							state <= uart_str_pkg::FTX_TAIL0;
						end else begin
							idx <= idx + LEN_W'(1);
						end
					end
				end
				uart_str_pkg::FTX_TAIL0: begin
					if (handshake) state <= uart_str_pkg::FTX_TAIL1;
				end
				uart_str_pkg::FTX_TAIL1: begin
					if (handshake) begin
						tail_sent <= 1'b1;
					end else if (tail_sent && byte_ready) begin
						// serializer idle again once the stop bit has gone out
						tail_sent <= 1'b0;
						state     <= uart_str_pkg::FTX_IDLE;
					end
				end
				default: state <= uart_str_pkg::FTX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/frame_rx.sv
//////////////////////////////
// string deframer
// delimiter hunt, payload staging
// string publish and frame errors
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_rx #(
	parameter int unsigned  MAX_LEN = 16,
	localparam int unsigned LEN_W   = $clog2(MAX_LEN + 1)
) (
	input  wire                   sys_clk,
	input  wire                   sys_rst_n,
	input  wire uart_str_pkg::byte_t byte_data,
	input  wire                   byte_valid,
	input  wire                   stop_err,
	output logic [8*MAX_LEN-1:0]  str,
	output logic [LEN_W-1:0]      len,
	output logic                  str_valid,
	output logic                  frame_err
);

	uart_str_pkg::frx_state_t state;
	logic [8*MAX_LEN-1:0]     stage;
	logic [LEN_W-1:0]         cnt;
	logic                     is_delim;
	logic                     store;
	// set after a broken frame so that its closing && opens no new one
	logic                     resync;

	assign is_delim = (byte_data == uart_str_pkg::DELIM);
	assign store    = byte_valid && !is_delim && (state == uart_str_pkg::FRX_PAYLOAD)
	                  && (cnt != LEN_W'(MAX_LEN));

	always_ff @(posedge sys_clk) begin
		if (state == uart_str_pkg::FRX_LEAD1 && byte_valid && is_delim) begin
			// zero fill above the received length
			stage <= '0;
		end else if (store) begin
			stage[8*cnt +: 8] <= byte_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= uart_str_pkg::FRX_HUNT;
			cnt       <= '0;
			resync    <= 1'b0;
			str       <= '0;
			len       <= '0;
			str_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			str_valid <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				uart_str_pkg::FRX_HUNT: begin
					if (byte_valid && is_delim) state <= uart_str_pkg::FRX_LEAD1;
				end
				uart_str_pkg::FRX_LEAD1: begin
					if (byte_valid) begin
						if (!is_delim) begin
							state <= uart_str_pkg::FRX_HUNT;
						end else if (resync) begin
							resync <= 1'b0;
							state  <= uart_str_pkg::FRX_HUNT;
						end else begin
							cnt   <= '0;
							state <= uart_str_pkg::FRX_PAYLOAD;
						end
					end else if (stop_err) begin
						state <= uart_str_pkg::FRX_HUNT;
					end
				end
				uart_str_pkg::FRX_PAYLOAD: begin
					if (stop_err) begin
						frame_err <= 1'b1;
						resync    <= 1'b1;
						state     <= uart_str_pkg::FRX_HUNT;
					end else if (byte_valid) begin
						if (is_delim) begin
							state <= uart_str_pkg::FRX_TAIL1;
						end else if (cnt == LEN_W'(MAX_LEN)) begin
							// overflow
							frame_err <= 1'b1;
							resync    <= 1'b1;
							state     <= uart_str_pkg::FRX_HUNT;
						end else begin
							cnt <= cnt + LEN_W'(1);
						end
					end
				end
				uart_str_pkg::FRX_TAIL1: begin
					if (stop_err) begin
						frame_err <= 1'b1;
						resync    <= 1'b1;
						state     <= uart_str_pkg::FRX_HUNT;
					end else if (byte_valid) begin
						if (is_delim) begin
							str       <= stage;
							len       <= cnt;
							str_valid <= 1'b1;
						end else begin
							// lone delimiter inside the frame
							frame_err <= 1'b1;
						end
						state <= uart_str_pkg::FRX_HUNT;
					end
				end
				default: state <= uart_str_pkg::FRX_HUNT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/uart_string_link.sv
//////////////////////////////
// serial string link top level
// framer, deframer, UART tx and rx
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_string_link #(
	parameter int unsigned  CLK_FREQ  = 125_000_000,
	parameter int unsigned  BAUD_RATE = 115_200,
	parameter int unsigned  MAX_LEN   = 16,
	localparam int unsigned LEN_W     = $clog2(MAX_LEN + 1)
) (
	input  wire                  sys_clk,
	input  wire                  sys_rst_n,

	input  wire [8*MAX_LEN-1:0]  tx_string,
	input  wire [LEN_W-1:0]      tx_length,
	input  wire                  tx_valid,
	output logic                 tx_ready,

	output logic [8*MAX_LEN-1:0] rx_string,
	output logic [LEN_W-1:0]     rx_length,
	output logic                 rx_valid,
	output logic                 rx_error,

	input  wire                  uart_rx_port,
	output logic                 uart_tx_port
);

	// framer to serializer
	uart_str_pkg::byte_t ftx_data;
	logic                ftx_valid;
	logic                ftx_ready;

	// deserializer to deframer
	uart_str_pkg::byte_t urx_data;
	logic                urx_valid;
	logic                urx_stop_err;

	frame_tx #(
		.MAX_LEN    (MAX_LEN)
	) u_frame_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.str        (tx_string),
		.len        (tx_length),
		.valid      (tx_valid),
		.ready      (tx_ready),
		.byte_data  (ftx_data),
		.byte_valid (ftx_valid),
		.byte_ready (ftx_ready)
	);

	uart_tx #(
		.CLK_FREQ   (CLK_FREQ),
		.BAUD_RATE  (BAUD_RATE)
	) u_uart_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.data       (ftx_data),
		.valid      (ftx_valid),
		.ready      (ftx_ready),
		.txd        (uart_tx_port)
	);

	uart_rx #(
		.CLK_FREQ   (CLK_FREQ),
		.BAUD_RATE  (BAUD_RATE)
	) u_uart_rx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.rxd        (uart_rx_port),
		.data       (urx_data),
		.valid      (urx_valid),
		.stop_err   (urx_stop_err)
	);

	frame_rx #(
		.MAX_LEN    (MAX_LEN)
	) u_frame_rx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (urx_data),
		.byte_valid (urx_valid),
		.stop_err   (urx_stop_err),
		.str        (rx_string),
		.len        (rx_length),
		.str_valid  (rx_valid),
		.frame_err  (rx_error)
	);

endmodule

`default_nettype wire

// File: test/tb_uart_string_link.sv
//////////////////////////////
// testbench for the string link
// loopback and bit-banged line
// directed tests and checks
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_uart_string_link;

	localparam int unsigned CLK_FREQ  = 125_000_000;
	localparam int unsigned BAUD_RATE = 7_812_500;
	localparam int unsigned MAX_LEN   = 16;
	localparam int unsigned LEN_W     = $clog2(MAX_LEN + 1);
	localparam int unsigned BIT_CYC   = 16;
	// longest frame is 20 characters of 160 cycles
	localparam int          FRAME_TO  = 4000;

	logic                 sys_clk;
	logic                 sys_rst_n;
	logic [8*MAX_LEN-1:0] tx_string;
	logic [LEN_W-1:0]     tx_length;
	logic                 tx_valid;
	wire                  tx_ready;
	wire  [8*MAX_LEN-1:0] rx_string;
	wire  [LEN_W-1:0]     rx_length;
	wire                  rx_valid;
	wire                  rx_error;
	wire                  uart_tx_port;
	wire                  rx_line;

	// line source is the DUT transmitter or the bit-banged level
	logic loopback_sel;
	logic bang_line;

	int                   errors;
	int                   checks;
	int                   valid_cnt = 0;
	int                   err_cnt = 0;
	logic [8*MAX_LEN-1:0] last_rx_string;
	logic [LEN_W-1:0]     last_rx_length;
	logic [8*MAX_LEN-1:0] rx_str_q[$];
	logic [LEN_W-1:0]     rx_len_q[$];
	logic [31:0]          rng_state;

	assign rx_line = loopback_sel ? uart_tx_port : bang_line;

	uart_string_link #(
		.CLK_FREQ     (CLK_FREQ),
		.BAUD_RATE    (BAUD_RATE),
		.MAX_LEN      (MAX_LEN)
	) DUT (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_valid     (tx_valid),
		.tx_ready     (tx_ready),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_valid     (rx_valid),
		.rx_error     (rx_error),
		.uart_rx_port (rx_line),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// receive monitor sampling the settled outputs at the falling edge
	always @(negedge sys_clk) begin
		if (rx_valid) begin
			valid_cnt      <= valid_cnt + 1;
			last_rx_string <= rx_string;
			last_rx_length <= rx_length;
			rx_str_q.push_back(rx_string);
			rx_len_q.push_back(rx_length);
		end
		if (rx_error) begin
			err_cnt <= err_cnt + 1;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// printable characters other than the delimiter
	function automatic logic [7:0] rand_char();
		logic [7:0] c;
		rng_state = xorshift32(rng_state);
		c = 8'h21 + 8'(rng_state % 94);
		if (c == 8'h26) c = 8'h41;
		return c;
	endfunction

	// byte 0 holds the first character with zeros above the length
	function automatic logic [8*MAX_LEN-1:0] pack_string(input string s);
		logic [8*MAX_LEN-1:0] p;
		p = '0;
		for (int i = 0; i < s.len() && i < MAX_LEN; i++) p[8*i +: 8] = s[i];
		return p;
	endfunction

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	task automatic wait_tx_ready(input string name);
		int n;
		n = 0;
		while (!tx_ready && n < FRAME_TO) begin
			@(negedge sys_clk);
			n++;
		end
		if (!tx_ready) begin
			errors++;
			$display("%s: timed out waiting for tx_ready", name);
		end
	endtask

	// waits until the valid or error counter reaches target
	task automatic wait_pulses(input string name, input bit on_err, input int target,
	                           input int limit);
		int n;
		n = 0;
		while ((on_err ? err_cnt : valid_cnt) < target && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if ((on_err ? err_cnt : valid_cnt) < target) begin
			errors++;
			$display("%s: timed out waiting for %s", name, on_err ? "rx_error" : "rx_valid");
		end
	endtask

	// holds tx_valid until accepted
	task automatic send_request(input string name, input logic [8*MAX_LEN-1:0] s,
	                            input logic [LEN_W-1:0] len);
		tx_string = s;
		tx_length = len;
		tx_valid  = 1'b1;
		wait_tx_ready(name);
		@(negedge sys_clk);
		tx_valid = 1'b0;
	endtask

	task automatic bang_bit(input logic b);
		bang_line = b;
		repeat (BIT_CYC) @(negedge sys_clk);
	endtask

	task automatic bang_byte(input logic [7:0] b, input logic stop);
		bang_bit(1'b0);
		for (int i = 0; i < 8; i++) bang_bit(b[i]);
		bang_bit(stop);
		// give the line a rising edge after a bad stop bit
		if (!stop) bang_bit(1'b1);
	endtask

	task automatic bang_string(input string s);
		for (int i = 0; i < s.len(); i++) bang_byte(s[i], 1'b1);
	endtask

	task automatic loopback_hello();
		int v0;
		int e0;
		v0 = valid_cnt;
		e0 = err_cnt;
		loopback_sel = 1'b1;
		send_request("hello", pack_string("hello"), 5);
		wait_pulses("hello", 1'b0, v0 + 1, 3 * FRAME_TO);
		wait_tx_ready("hello");
		idle(200);
		check("hello string", pack_string("hello"), last_rx_string);
		check("hello length", 5, last_rx_length);
		check("hello valid count", v0 + 1, valid_cnt);
		check("hello errors", e0, err_cnt);
		check("hello tx_ready", 1, tx_ready);
	endtask

	task automatic empty_frame();
		int v0;
		v0 = valid_cnt;
		send_request("empty", '0, 0);
		wait_pulses("empty", 1'b0, v0 + 1, 3 * FRAME_TO);
		wait_tx_ready("empty");
		check("empty length", 0, last_rx_length);
		check("empty string", 0, last_rx_string);
	endtask

	task automatic back_to_back();
		logic [8*MAX_LEN-1:0] exp_str[8];
		logic [LEN_W-1:0]     exp_len[8];
		int                   v0;
		int                   e0;
		v0 = valid_cnt;
		e0 = err_cnt;
		rx_str_q.delete();
		rx_len_q.delete();
		for (int k = 0; k < 8; k++) begin
			rng_state  = xorshift32(rng_state);
			exp_len[k] = LEN_W'(1 + rng_state % MAX_LEN);
			exp_str[k] = '0;
			for (int i = 0; i < exp_len[k]; i++) exp_str[k][8*i +: 8] = rand_char();
			send_request("back to back", exp_str[k], exp_len[k]);
		end
		wait_pulses("back to back", 1'b0, v0 + 8, 12 * FRAME_TO);
		wait_tx_ready("back to back");
		check("back to back count", 8, rx_str_q.size());
		for (int k = 0; k < 8 && k < rx_str_q.size(); k++) begin
			check($sformatf("back to back string %0d", k), exp_str[k], rx_str_q[k]);
			check($sformatf("back to back length %0d", k), exp_len[k], rx_len_q[k]);
		end
		check("back to back errors", e0, err_cnt);
	endtask

	task automatic malformed_frame();
		int v0;
		int e0;
		v0 = valid_cnt;
		e0 = err_cnt;
		loopback_sel = 1'b0;
		bang_string("&&ab&x");
		wait_pulses("malformed", 1'b1, e0 + 1, FRAME_TO);
		idle(50);
		check("malformed error count", e0 + 1, err_cnt);
		check("malformed valid count", v0, valid_cnt);
		bang_string("&&ok&&");
		wait_pulses("recovery", 1'b0, v0 + 1, FRAME_TO);
		check("recovery string", pack_string("ok"), last_rx_string);
		check("recovery length", 2, last_rx_length);
	endtask

	task automatic overflow_frame();
		logic [8*MAX_LEN-1:0] exp;
		logic [7:0]           c;
		int                   v0;
		int                   e0;
		v0 = valid_cnt;
		e0 = err_cnt;
		// noise outside any frame
		bang_string("zz&&");
		for (int i = 0; i < MAX_LEN + 1; i++) bang_byte(rand_char(), 1'b1);
		bang_string("&&");
		wait_pulses("overflow", 1'b1, e0 + 1, FRAME_TO);
		idle(50);
		check("overflow error count", e0 + 1, err_cnt);
		check("overflow valid count", v0, valid_cnt);
		exp = '0;
		bang_string("&&");
		for (int i = 0; i < MAX_LEN; i++) begin
			c            = rand_char();
			exp[8*i +: 8] = c;
			bang_byte(c, 1'b1);
		end
		bang_string("&&");
		wait_pulses("full length", 1'b0, v0 + 1, FRAME_TO);
		check("full length string", exp, last_rx_string);
		check("full length length", MAX_LEN, last_rx_length);
		check("full length errors", e0 + 1, err_cnt);
	endtask

	task automatic bad_stop_bit();
		int v0;
		int e0;
		v0 = valid_cnt;
		e0 = err_cnt;
		bang_string("&&a");
		bang_byte("b", 1'b0);
		bang_string("&&");
		wait_pulses("bad stop", 1'b1, e0 + 1, FRAME_TO);
		idle(50);
		check("bad stop error count", e0 + 1, err_cnt);
		check("bad stop valid count", v0, valid_cnt);
	endtask

	initial begin
		sys_rst_n    = 1'b0;
		tx_string    = '0;
		tx_length    = '0;
		tx_valid     = 1'b0;
		loopback_sel = 1'b1;
		bang_line    = 1'b1;
		errors       = 0;
		checks       = 0;
		rng_state    = 32'd53318;
		repeat (16) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
		idle(4);
		check("reset tx_ready", 1, tx_ready);
		check("reset line", 1, uart_tx_port);

		loopback_hello();
		empty_frame();
		back_to_back();
		malformed_frame();
		overflow_frame();
		bad_stop_bit();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/uart_str_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/frame_tx.sv
design/frame_rx.sv
design/uart_string_link.sv
test/tb_uart_string_link.sv

// File: Bender.yml
package:
  name: uart_string_link

sources:
  - files:
      - design/uart_str_pkg.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/frame_tx.sv
      - design/frame_rx.sv
      - design/uart_string_link.sv
  - target: test
    files:
      - test/tb_uart_string_link.sv
